// ==== Bender.yml ====
package:
  name: cpu

sources:
  - cpu_pkg.sv
  - fetch_stage.sv
  - decode_stage.sv
  - reg_file.sv
  - execute_stage.sv
  - mem_stage.sv
  - cpu_top.sv
  - target: test
    files:
      - cpu_props.sv
      - cpu_tb.sv

// ==== cpu_pkg.sv ====
package cpu_pkg;

  // Datapath widths
  localparam int DATA_W   = 32;
  localparam int REG_NO_W = 4;
  localparam int IMM_W    = 16;

  typedef logic [DATA_W-1:0]   word_t;
  typedef logic [REG_NO_W-1:0] reg_no_t;

  localparam word_t INST_BYTES = 32'd4;   // PC step
  localparam word_t NOP_INST   = '0;      // ALUR with op2 0, rd 0

  // Memories, word addressed through bits 11:2
  localparam word_t START_PC   = 32'h0000_0100;
  localparam int    IMEM_WORDS = 1024;
  localparam int    DMEM_WORDS = 1024;
  localparam int    IMEM_IDX_W = $clog2(IMEM_WORDS);
  localparam int    DMEM_IDX_W = $clog2(DMEM_WORDS);
  localparam string PROG_FILE  = "program.hex";

  // I/O window, stores here bypass data memory
  localparam word_t IO_BASE   = 32'hFFFF_F000;
  localparam word_t IO_LIMIT  = 32'hFFFF_F120;   // Exclusive
  localparam word_t LEDR_ADDR = 32'hFFFF_F020;
  localparam int    LEDR_W    = 10;

  // Primary opcodes, inst[31:26]
  typedef enum logic [5:0] {
    OP1_ALUR = 6'b000000,
    OP1_BEQ  = 6'b001000,
    OP1_BLT  = 6'b001001,
    OP1_BLE  = 6'b001010,
    OP1_BNE  = 6'b001011,
    OP1_JAL  = 6'b001100,
    OP1_LW   = 6'b010010,
    OP1_SW   = 6'b011010,
    OP1_ADDI = 6'b100000,
    OP1_ANDI = 6'b100100,
    OP1_ORI  = 6'b100101,
    OP1_XORI = 6'b100110
  } op1_e;

  // ALUR function codes, inst[25:18]
  typedef enum logic [7:0] {
    OP2_EQ   = 8'b00001000,
    OP2_LT   = 8'b00001001,
    OP2_LE   = 8'b00001010,
    OP2_NE   = 8'b00001011,
    OP2_ADD  = 8'b00100000,
    OP2_AND  = 8'b00100100,
    OP2_OR   = 8'b00100101,
    OP2_XOR  = 8'b00100110,
    OP2_SUB  = 8'b00101000,
    OP2_NAND = 8'b00101100,
    OP2_NOR  = 8'b00101101,
    OP2_NXOR = 8'b00101110,
    OP2_RSHF = 8'b00110000,
    OP2_LSHF = 8'b00110001
  } op2_e;

  typedef struct packed {
    logic is_br;
    logic is_jal;
    logic rd_mem;
    logic wr_mem;
    logic wr_reg;
  } ctrl_t;

  typedef struct packed {
    word_t   pc;       // Address of the instruction itself
    op1_e    op1;
    op2_e    op2;
    word_t   val_a;    // Rs value
    word_t   val_b;    // Rt value
    word_t   imm;      // Sign extended
    reg_no_t wregno;
    ctrl_t   ctrl;
  } id_ex_t;

  typedef struct packed {
    word_t   aluout;   // Result, address or link
    word_t   st_val;
    reg_no_t wregno;
    logic    rd_mem;
    logic    wr_mem;
    logic    wr_reg;
  } ex_mem_t;

  typedef struct packed {
    word_t   value;
    reg_no_t wregno;
    logic    wr_reg;
  } mem_wb_t;

  typedef struct packed {
    logic  valid;
    word_t addr;
    word_t data;
  } io_wr_t;

endpackage

// ==== cpu_props.sv ====
module cpu_props (
  input logic                       clk,
  input logic                       reset,
  input logic [cpu_pkg::LEDR_W-1:0] ledr,
  input cpu_pkg::io_wr_t            io_wr
);
  import cpu_pkg::*;

  int fail_cnt = 0;   // Assertion failures so far

  // Outputs quiet while reset is held
  a_reset_quiet: assert property (@(posedge clk) reset |-> (ledr == '0 && !io_wr.valid))
    else
    begin
      $error("ledr or io_wr.valid active during reset");
      fail_cnt++;
    end

  // Device writes only inside the I/O window
  a_io_range: assert property (@(posedge clk) disable iff (reset)
      io_wr.valid |-> (io_wr.addr >= IO_BASE && io_wr.addr < IO_LIMIT))
    else
    begin
      $error("io_wr.valid with address outside the I/O range");
      fail_cnt++;
    end

  // LED register picks up the low bits one cycle later
  a_ledr_follow: assert property (@(posedge clk) disable iff (reset)
      (io_wr.valid && io_wr.addr == LEDR_ADDR) |=> (ledr == $past(io_wr.data[LEDR_W-1:0])))
    else
    begin
      $error("ledr does not follow the LEDR write");
      fail_cnt++;
    end

  a_data_known: assert property (@(posedge clk) disable iff (reset)
      io_wr.valid |-> !$isunknown(io_wr.data))
    else
    begin
      $error("io_wr.data unknown while valid");
      fail_cnt++;
    end

endmodule

bind cpu_top cpu_props u_props (.*);

// ==== cpu_tb.sv ====
module cpu_tb;
  import cpu_pkg::*;

  localparam int N_EXP          = 26;              // Device stores in program.hex
  localparam int PROG_WORDS     = 71;
  localparam int TIMEOUT_CYCLES = PROG_WORDS * 5 + 45;   // Worst stall per word plus slack
  localparam int DRAIN_CYCLES   = 20;              // Catch stray stores after the last one

  logic              clk;
  logic              reset;
  logic [LEDR_W-1:0] ledr;
  io_wr_t            io_wr;

  word_t exp_data [N_EXP];
  int    n_seen  = 0;
  int    n_pass  = 0;
  int    n_fail  = 0;
  int    n_extra = 0;

  cpu_top u_dut (
    .clk   (clk),
    .reset (reset),
    .ledr  (ledr),
    .io_wr (io_wr)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;   // Period 8

  // Reference results from the ISA rules on the program constants
  task automatic build_expected();
    logic signed [DATA_W-1:0] a;
    logic signed [DATA_W-1:0] b;
    begin
      a = -7;   // r2
      b = 5;    // r3
      exp_data[0]  = (a == b) ? 32'd1 : 32'd0;
      exp_data[1]  = (a <  b) ? 32'd1 : 32'd0;   // Signed
      exp_data[2]  = (a <= b) ? 32'd1 : 32'd0;
      exp_data[3]  = (a != b) ? 32'd1 : 32'd0;
      exp_data[4]  = a + b;
      exp_data[5]  = a & b;
      exp_data[6]  = a | b;
      exp_data[7]  = a ^ b;
      exp_data[8]  = a - b;
      exp_data[9]  = ~(a & b);
      exp_data[10] = ~(a | b);
      exp_data[11] = ~(a ^ b);
      exp_data[12] = a >>> b;                   // Sign fills
      exp_data[13] = a << b;
      exp_data[14] = a + 32'sd16;               // ADDI
      exp_data[15] = a & 32'h0000_00F0;         // ANDI
      exp_data[16] = b | 32'hFFFF_8000;         // ORI with a negative immediate
      exp_data[17] = b ^ 32'h0000_00FF;         // XORI
      exp_data[18] = a + b;                     // Spaced ADD
      exp_data[19] = a;                         // SW then LW round trip
      for (int i = 20; i < 24; i++)
        exp_data[i] = 32'h55;                   // Not-taken fall-through markers
      exp_data[24] = 32'h204 + INST_BYTES;      // JAL link
      exp_data[25] = b;                         // First word after the return
    end
  endtask

  task automatic check_store();
    logic ok;
    begin
      ok = 1'b1;
      if (n_seen >= N_EXP)
      begin
        $display("Unexpected store at time %0t to %h with %h", $time, io_wr.addr, io_wr.data);
        n_extra++;
      end
      else
      begin
        assert (io_wr.addr == LEDR_ADDR)
        else
        begin
          $display("[FAIL] time %0t io_wr.addr got %h expected %h",
                   $time, io_wr.addr, LEDR_ADDR);
          ok = 1'b0;
        end
        assert (io_wr.data == exp_data[n_seen])
        else
        begin
          $display("[FAIL] time %0t io_wr.data got %h expected %h",
                   $time, io_wr.data, exp_data[n_seen]);
          ok = 1'b0;
        end
        if (ok)
          n_pass++;
        else
          n_fail++;
        $display("store %0d: data %h %s", n_seen, io_wr.data, ok ? "ok" : "wrong");
        n_seen++;
      end
    end
  endtask

  // Port is combinational from the execute latch and steady by the falling edge
  always @(negedge clk)
  begin
    if (!reset && io_wr.valid)
      check_store();
  end

  initial
  begin
    reset = 1'b0;
    build_expected();
    #1 reset = 1'b1;   // Rising edge seen by every async reset
    repeat (8) @(posedge clk);
    #1 reset = 1'b0;
    while (n_seen < N_EXP)
      @(posedge clk);
    repeat (DRAIN_CYCLES) @(posedge clk);
    $display("Stores %0d of %0d, passed %0d, failed %0d, extra %0d, assertion failures %0d",
             n_seen, N_EXP, n_pass, n_fail, n_extra, u_dut.u_props.fail_cnt);
    if (n_fail == 0 && n_extra == 0 && u_dut.u_props.fail_cnt == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

  // Watchdog
  initial
  begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles with %0d of %0d stores seen",
             TIMEOUT_CYCLES, n_seen, N_EXP);
    $display("Some tests failed");
    $finish;
  end

endmodule

// ==== cpu_top.sv ====
module cpu_top (
  input  logic                       clk,
  input  logic                       reset,
  output logic [cpu_pkg::LEDR_W-1:0] ledr,
  output cpu_pkg::io_wr_t            io_wr
);
  import cpu_pkg::*;

  word_t   inst;         // Fetch latch
  word_t   pc_fe;
  reg_no_t rs;
  reg_no_t rt;
  word_t   rdata_a;
  word_t   rdata_b;
  logic    stall;        // Data hazard hold
  logic    jump_stall;   // Control op in decode
  logic    redirect;
  word_t   target;
  id_ex_t  id_ex;
  ex_mem_t ex_mem;
  reg_no_t ex_wregno;
  reg_no_t mem_wregno;
  mem_wb_t wb;

  fetch_stage u_fetch (
    .clk        (clk),
    .reset      (reset),
    .stall      (stall),
    .jump_stall (jump_stall),
    .redirect   (redirect),
    .target     (target),
    .inst       (inst),
    .pc         (pc_fe)
  );

  decode_stage u_decode (
    .clk        (clk),
    .reset      (reset),
    .inst       (inst),
    .pc         (pc_fe),
    .rdata_a    (rdata_a),
    .rdata_b    (rdata_b),
    .ex_wregno  (ex_wregno),
    .mem_wregno (mem_wregno),
    .redirect   (redirect),
    .rs         (rs),
    .rt         (rt),
    .stall      (stall),
    .jump_stall (jump_stall),
    .id_ex      (id_ex)
  );

  reg_file u_regs (
    .clk     (clk),
    .reset   (reset),
    .rs      (rs),
    .rt      (rt),
    .rdata_a (rdata_a),
    .rdata_b (rdata_b),
    .wb      (wb)
  );

  execute_stage u_execute (
    .clk       (clk),
    .reset     (reset),
    .id_ex     (id_ex),
    .redirect  (redirect),
    .target    (target),
    .ex_mem    (ex_mem),
    .ex_wregno (ex_wregno)
  );

  mem_stage u_mem (
    .clk        (clk),
    .reset      (reset),
    .ex_mem     (ex_mem),
    .wb         (wb),
    .mem_wregno (mem_wregno),
    .io_wr      (io_wr),
    .ledr       (ledr)
  );

endmodule

// ==== decode_stage.sv ====
module decode_stage (
  input  logic              clk,
  input  logic              reset,
  input  cpu_pkg::word_t    inst,
  input  cpu_pkg::word_t    pc,
  input  cpu_pkg::word_t    rdata_a,
  input  cpu_pkg::word_t    rdata_b,
  input  cpu_pkg::reg_no_t  ex_wregno,
  input  cpu_pkg::reg_no_t  mem_wregno,
  input  logic              redirect,
  output cpu_pkg::reg_no_t  rs,
  output cpu_pkg::reg_no_t  rt,
  output logic              stall,
  output logic              jump_stall,
  output cpu_pkg::id_ex_t   id_ex
);
  import cpu_pkg::*;

  op1_e             op1;
  op2_e             op2;
  logic [IMM_W-1:0] imm_f;
  reg_no_t          rd;
  reg_no_t          wregno;
  ctrl_t            ctrl;
  logic             is_ext;      // ALUR with a real function code
  logic             is_alui;
  logic             match_rs;
  logic             match_rt;
  id_ex_t           id_ex_d;

  // Instruction fields
  assign op1   = op1_e'(inst[31:26]);
  assign op2   = op2_e'(inst[25:18]);
  assign imm_f = inst[23:8];
  assign rd    = inst[11:8];
  assign rs    = inst[7:4];
  assign rt    = inst[3:0];

  assign ctrl.is_br  = op1 inside {OP1_BEQ, OP1_BLT, OP1_BLE, OP1_BNE};
  assign ctrl.is_jal = (op1 == OP1_JAL);
  assign ctrl.rd_mem = (op1 == OP1_LW);
  assign ctrl.wr_mem = (op1 == OP1_SW);
  // r0 never written, so NOPs and r0 targets leave it at zero
  assign ctrl.wr_reg = !(ctrl.is_br || ctrl.wr_mem) && (wregno != '0);

  // Rd for ALUR, nothing for branch and SW, Rt for the rest
  assign wregno = (op1 == OP1_ALUR)            ? rd  :
                  (ctrl.is_br || ctrl.wr_mem)  ? '0  : rt;

  assign is_ext  = (op1 == OP1_ALUR) && (inst[25:18] != '0);
  assign is_alui = op1 inside {OP1_ADDI, OP1_ANDI, OP1_ORI, OP1_XORI};

  // Pending writes in execute, memory and write-back
  assign match_rs = (rs != '0) &&
                    (rs == id_ex.wregno || rs == ex_wregno || rs == mem_wregno);
  assign match_rt = (rt != '0) &&
                    (rt == id_ex.wregno || rt == ex_wregno || rt == mem_wregno);

  assign stall = (is_ext      && (match_rs || match_rt)) ||
                 (ctrl.is_br  && (match_rs || match_rt)) ||
                 (ctrl.wr_mem && (match_rs || match_rt)) ||
                 ((ctrl.is_jal || ctrl.rd_mem || is_alui) && match_rs);   // Rs only

  assign jump_stall = ctrl.is_br || ctrl.is_jal;

  always_comb
  begin
    id_ex_d.pc     = pc;
    id_ex_d.op1    = op1;
    id_ex_d.op2    = op2;
    id_ex_d.val_a  = rdata_a;
    id_ex_d.val_b  = rdata_b;
    id_ex_d.imm    = {{(DATA_W-IMM_W){imm_f[IMM_W-1]}}, imm_f};   // Sign extend
    id_ex_d.wregno = wregno;
    id_ex_d.ctrl   = ctrl;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      id_ex <= '0;
    else if (stall || redirect)
      id_ex <= '0;               // Bubble into execute
    else
      id_ex <= id_ex_d;
  end

endmodule

// ==== execute_stage.sv ====
module execute_stage (
  input  logic              clk,
  input  logic              reset,
  input  cpu_pkg::id_ex_t   id_ex,
  output logic              redirect,
  output cpu_pkg::word_t    target,
  output cpu_pkg::ex_mem_t  ex_mem,
  output cpu_pkg::reg_no_t  ex_wregno
);
  import cpu_pkg::*;

  logic signed [DATA_W-1:0] a_s;
  logic signed [DATA_W-1:0] b_s;
  word_t                    alu;
  word_t                    pc_next;    // Link value and branch base
  word_t                    imm_x4;     // Word offset in bytes
  logic                     br_cond;

  assign a_s     = id_ex.val_a;
  assign b_s     = id_ex.val_b;
  assign pc_next = id_ex.pc + INST_BYTES;
  assign imm_x4  = id_ex.imm << 2;

  // Signed compares for branches
  always_comb
  begin
    case (id_ex.op1)
      OP1_BEQ: br_cond = (a_s == b_s);
      OP1_BLT: br_cond = (a_s <  b_s);
      OP1_BLE: br_cond = (a_s <= b_s);
      OP1_BNE: br_cond = (a_s != b_s);
      default: br_cond = 1'b0;
    endcase
  end

  always_comb
  begin
    alu = '0;
    if (id_ex.op1 == OP1_ALUR)
    begin
      case (id_ex.op2)
        OP2_EQ:   alu = {{(DATA_W-1){1'b0}}, a_s == b_s};
        OP2_LT:   alu = {{(DATA_W-1){1'b0}}, a_s <  b_s};
        OP2_LE:   alu = {{(DATA_W-1){1'b0}}, a_s <= b_s};
        OP2_NE:   alu = {{(DATA_W-1){1'b0}}, a_s != b_s};
        OP2_ADD:  alu = a_s + b_s;
        OP2_AND:  alu = a_s & b_s;
        OP2_OR:   alu = a_s | b_s;
        OP2_XOR:  alu = a_s ^ b_s;
        OP2_SUB:  alu = a_s - b_s;
        OP2_NAND: alu = ~(a_s & b_s);
        OP2_NOR:  alu = ~(a_s | b_s);
        OP2_NXOR: alu = ~(a_s ^ b_s);
        OP2_RSHF: alu = a_s >>> id_ex.val_b;   // Arithmetic
        OP2_LSHF: alu = id_ex.val_b < DATA_W ? id_ex.val_a << id_ex.val_b : '0;
        default:  alu = '0;
      endcase
    end
    else if (id_ex.op1 inside {OP1_LW, OP1_SW, OP1_ADDI})
      alu = id_ex.val_a + id_ex.imm;       // Also the memory address
    else if (id_ex.op1 == OP1_ANDI)
      alu = id_ex.val_a & id_ex.imm;
    else if (id_ex.op1 == OP1_ORI)
      alu = id_ex.val_a | id_ex.imm;
    else if (id_ex.op1 == OP1_XORI)
      alu = id_ex.val_a ^ id_ex.imm;
  end

  assign redirect = id_ex.ctrl.is_jal || (id_ex.ctrl.is_br && br_cond);
  // JAL goes to Rs + 4*imm, a taken branch is relative to the next word
  assign target   = id_ex.ctrl.is_jal ? id_ex.val_a + imm_x4 : pc_next + imm_x4;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      ex_mem <= '0;
    else
    begin
      ex_mem.aluout <= id_ex.ctrl.is_jal ? pc_next : alu;   // Link for JAL
      ex_mem.st_val <= id_ex.val_b;
      ex_mem.wregno <= id_ex.wregno;
      ex_mem.rd_mem <= id_ex.ctrl.rd_mem;
      ex_mem.wr_mem <= id_ex.ctrl.wr_mem;
      ex_mem.wr_reg <= id_ex.ctrl.wr_reg;
    end
  end

  assign ex_wregno = ex_mem.wregno;

endmodule

// ==== fetch_stage.sv ====
module fetch_stage (
  input  logic           clk,
  input  logic           reset,
  input  logic           stall,
  input  logic           jump_stall,
  input  logic           redirect,
  input  cpu_pkg::word_t target,
  output cpu_pkg::word_t inst,
  output cpu_pkg::word_t pc
);
  import cpu_pkg::*;

  word_t pc_q;                    // Next fetch address
  word_t imem [IMEM_WORDS];
  word_t inst_w;

  initial
  begin
    $readmemh(PROG_FILE, imem);   // Program image
  end

  assign inst_w = imem[pc_q[IMEM_IDX_W+1:2]];

  // Priority is redirect, then hazard hold, then control bubble
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      pc_q <= START_PC;
      inst <= NOP_INST;
      pc   <= '0;
    end
    else if (redirect)
    begin
      pc_q <= target;             // Taken branch or JAL
      inst <= NOP_INST;           // Drop the wrong-path word
    end
    else if (!stall)
    begin
      if (jump_stall)
        inst <= NOP_INST;         // PC waits for the outcome
      else
      begin
        pc_q <= pc_q + INST_BYTES;
        inst <= inst_w;
        pc   <= pc_q;
      end
    end
  end

endmodule

// ==== filelist.f ====
cpu_pkg.sv
fetch_stage.sv
decode_stage.sv
reg_file.sv
execute_stage.sv
mem_stage.sv
cpu_top.sv
cpu_props.sv
cpu_tb.sv

// ==== mem_stage.sv ====
module mem_stage (
  input  logic                       clk,
  input  logic                       reset,
  input  cpu_pkg::ex_mem_t           ex_mem,
  output cpu_pkg::mem_wb_t           wb,
  output cpu_pkg::reg_no_t           mem_wregno,
  output cpu_pkg::io_wr_t            io_wr,
  output logic [cpu_pkg::LEDR_W-1:0] ledr
);
  import cpu_pkg::*;

  word_t                 dmem [DMEM_WORDS];
  logic [DMEM_IDX_W-1:0] idx;
  logic                  is_io;
  word_t                 rd_val;

  initial
  begin
    $readmemh(PROG_FILE, dmem);   // Same image as instruction memory
  end

  assign idx    = ex_mem.aluout[DMEM_IDX_W+1:2];
  assign is_io  = (ex_mem.aluout >= IO_BASE) && (ex_mem.aluout < IO_LIMIT);
  assign rd_val = is_io ? '0 : dmem[idx];   // No readable devices

  // Device stores leave on the port in the same cycle
  assign io_wr.valid = ex_mem.wr_mem && is_io;
  assign io_wr.addr  = ex_mem.aluout;
  assign io_wr.data  = ex_mem.st_val;

  always_ff @(posedge clk)
  begin
    if (ex_mem.wr_mem && !is_io)
      dmem[idx] <= ex_mem.st_val;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      ledr <= '0;
      wb   <= '0;
    end
    else
    begin
      if (io_wr.valid && (io_wr.addr == LEDR_ADDR))
        ledr <= io_wr.data[LEDR_W-1:0];   // Low bits only
      wb.value  <= ex_mem.rd_mem ? rd_val : ex_mem.aluout;
      wb.wregno <= ex_mem.wregno;
      wb.wr_reg <= ex_mem.wr_reg;
    end
  end

  assign mem_wregno = wb.wregno;

endmodule

// ==== program.hex ====
// One 32-bit instruction word per line, loaded from byte address 0x100
// Word index 0x40 is START_PC
@40
80F02001 // r1 = LEDR address
80FFF902 // r2 = -7
80000503 // r3 = 5
800BAD08 // r8 = 0xBAD
80005509 // r9 = 0x55
00200423 // EQ
68000014
00240423 // LT
68000014
00280423 // LE
68000014
002C0423 // NE
68000014
00800423 // ADD
68000014
00900423 // AND
68000014
00940423 // OR
68000014
00980423 // XOR
68000014
00A00423 // SUB
68000014
00B00423 // NAND
68000014
00B40423 // NOR
68000014
00B80423 // NXOR
68000014
00C00423 // RSHF
68000014
00C40423 // LSHF
68000014
80001026 // ADDI
68000016
9000F026 // ANDI
68000016
94800036 // ORI
68000016
9800FF36 // XORI
68000016
00800523 // ADD spaced by NOPs
00000000
00000000
00000000
68000015
68080002 // SW r2 to 0x800
48080007 // LW r7
68000017
20000123 // BEQ not taken
68000019
20000122 // BEQ taken
68000018
24000123 // BLT taken
68000018
24000132 // BLT not taken
68000019
28000122 // BLE taken
68000018
28000132 // BLE not taken
68000019
2C000123 // BNE taken
68000018
2C000122 // BNE not taken
68000019
3000840A // JAL r10 to 0x210
68000013 // Return lands here
20FFFF00 // Halt loop
6800001A // Routine, store link
300000A0 // Return through r10
68000018 // Never reached

// ==== reg_file.sv ====
module reg_file (
  input  logic              clk,
  input  logic              reset,
  input  cpu_pkg::reg_no_t  rs,
  input  cpu_pkg::reg_no_t  rt,
  output cpu_pkg::word_t    rdata_a,
  output cpu_pkg::word_t    rdata_b,
  input  cpu_pkg::mem_wb_t  wb
);
  import cpu_pkg::*;

  word_t regs [2**REG_NO_W];

  assign rdata_a = regs[rs];   // Async read
  assign rdata_b = regs[rt];

  // Falling edge write, visible to decode at the next rising edge
  always_ff @(negedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < 2**REG_NO_W; i++)
        regs[i] <= '0;
    end
    else if (wb.wr_reg)
      regs[wb.wregno] <= wb.value;
  end

endmodule
